/* logic/buffer_ram.sv */
`timescale 1ns/10ps

module buffer_ram #(
    parameter type entry_t = logic,
    parameter int  ADDR_W  = pkt_buffer_pkg::ADDR_W_DEFAULT
) (
    input  logic              clk,

    ram_port_a_if.memory      port_a,

    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output entry_t            rd_data
);

    localparam int DEPTH = 1 << ADDR_W;

    entry_t mem [0:DEPTH-1];

    //////////////////////////////////////////////////////////////////////
    // port a, shared between datapath and cpu
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (port_a.en)
        begin
            if (port_a.we)
            begin
                mem[port_a.addr] <= port_a.wdata;
            end
            port_a.rdata <= mem[port_a.addr];  // old value on write
        end
    end

    //////////////////////////////////////////////////////////////////////
    // port b, datapath read only
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];  // holds otherwise
        end
    end

endmodule

/* logic/pkt_buffer_pkg.sv */
package pkt_buffer_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W         = 64;
    localparam int KEEP_W         = DATA_W / 8;  // one bit per byte
    localparam int RANK_W         = 32;
    localparam int ADDR_W_DEFAULT = 8;           // 256 entries

    //////////////////////////////////////////////////////////////////////
    // entry types
    //////////////////////////////////////////////////////////////////////

    // packet buffer word, last on top
    typedef struct packed {
        logic              last;
        logic [KEEP_W-1:0] keep;
        logic [DATA_W-1:0] data;
    } pkt_entry_t;

    // scheduling rank carried with the packet
    typedef logic [RANK_W-1:0] rank_entry_t;

    //////////////////////////////////////////////////////////////////////
    // cpu request target
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        TARGET_PKT  = 1'b0,
        TARGET_RANK = 1'b1
    } cpu_target_e;

endpackage

/* logic/pkt_buffer_top.sv */
`timescale 1ns/10ps

module pkt_buffer_top #(
    parameter int ADDR_W = pkt_buffer_pkg::ADDR_W_DEFAULT
) (
    input  logic                        clk,
    input  logic                        rstn,

    // datapath write
    input  logic                        dp_wr_en,
    input  logic [ADDR_W-1:0]           dp_wr_addr,
    input  pkt_buffer_pkg::pkt_entry_t  dp_wr_pkt,
    input  pkt_buffer_pkg::rank_entry_t dp_wr_rank,

    // datapath read
    input  logic                        dp_rd_en,
    input  logic [ADDR_W-1:0]           dp_rd_addr,
    output logic                        m_valid,
    output pkt_buffer_pkg::pkt_entry_t  m_pkt,
    output pkt_buffer_pkg::rank_entry_t m_rank,

    // cpu request / response
    input  logic                        cpu_req_valid,
    input  logic                        cpu_req_write,
    input  pkt_buffer_pkg::cpu_target_e cpu_req_target,
    input  logic [ADDR_W-1:0]           cpu_req_addr,
    input  pkt_buffer_pkg::pkt_entry_t  cpu_wr_pkt,
    input  pkt_buffer_pkg::rank_entry_t cpu_wr_rank,
    output logic                        cpu_req_ready,
    output logic                        cpu_resp_valid,
    output logic                        cpu_resp_write,
    output pkt_buffer_pkg::pkt_entry_t  cpu_rd_pkt,
    output pkt_buffer_pkg::rank_entry_t cpu_rd_rank
);

    ram_port_a_if #(
        .entry_t (pkt_buffer_pkg::pkt_entry_t),
        .ADDR_W  (ADDR_W)
    ) pkt_a ();

    ram_port_a_if #(
        .entry_t (pkt_buffer_pkg::rank_entry_t),
        .ADDR_W  (ADDR_W)
    ) rank_a ();

    port_a_arbiter #(
        .ADDR_W (ADDR_W)
    ) i_arbiter (
        .clk            (clk),
        .rstn           (rstn),
        .dp_wr_en       (dp_wr_en),
        .dp_wr_addr     (dp_wr_addr),
        .dp_wr_pkt      (dp_wr_pkt),
        .dp_wr_rank     (dp_wr_rank),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_write  (cpu_req_write),
        .cpu_req_target (cpu_req_target),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_wr_pkt     (cpu_wr_pkt),
        .cpu_wr_rank    (cpu_wr_rank),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_write (cpu_resp_write),
        .cpu_rd_pkt     (cpu_rd_pkt),
        .cpu_rd_rank    (cpu_rd_rank),
        .pkt_a          (pkt_a.arbiter),
        .rank_a         (rank_a.arbiter)
    );

    //////////////////////////////////////////////////////////////////////
    // buffers, port b shared by the datapath read
    //////////////////////////////////////////////////////////////////////

    buffer_ram #(
        .entry_t (pkt_buffer_pkg::pkt_entry_t),
        .ADDR_W  (ADDR_W)
    ) pkt_ram (
        .clk     (clk),
        .port_a  (pkt_a.memory),
        .rd_en   (dp_rd_en),
        .rd_addr (dp_rd_addr),
        .rd_data (m_pkt)
    );

    buffer_ram #(
        .entry_t (pkt_buffer_pkg::rank_entry_t),
        .ADDR_W  (ADDR_W)
    ) rank_ram (
        .clk     (clk),
        .port_a  (rank_a.memory),
        .rd_en   (dp_rd_en),
        .rd_addr (dp_rd_addr),
        .rd_data (m_rank)
    );

    // valid follows the registered read
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            m_valid <= 1'b0;
        end
        else
        begin
            m_valid <= dp_rd_en;
        end
    end

endmodule

/* logic/port_a_arbiter.sv */
`timescale 1ns/10ps

module port_a_arbiter #(
    parameter int ADDR_W = pkt_buffer_pkg::ADDR_W_DEFAULT
) (
    input  logic                        clk,
    input  logic                        rstn,

    // datapath write, always has priority
    input  logic                        dp_wr_en,
    input  logic [ADDR_W-1:0]           dp_wr_addr,
    input  pkt_buffer_pkg::pkt_entry_t  dp_wr_pkt,
    input  pkt_buffer_pkg::rank_entry_t dp_wr_rank,

    // cpu request
    input  logic                        cpu_req_valid,
    input  logic                        cpu_req_write,
    input  pkt_buffer_pkg::cpu_target_e cpu_req_target,
    input  logic [ADDR_W-1:0]           cpu_req_addr,
    input  pkt_buffer_pkg::pkt_entry_t  cpu_wr_pkt,
    input  pkt_buffer_pkg::rank_entry_t cpu_wr_rank,
    output logic                        cpu_req_ready,

    // cpu response
    output logic                        cpu_resp_valid,
    output logic                        cpu_resp_write,
    output pkt_buffer_pkg::pkt_entry_t  cpu_rd_pkt,
    output pkt_buffer_pkg::rank_entry_t cpu_rd_rank,

    ram_port_a_if.arbiter               pkt_a,
    ram_port_a_if.arbiter               rank_a
);

    typedef enum logic {
        ST_IDLE         = 1'b0,
        ST_WAIT_DP_IDLE = 1'b1
    } state_t;

    state_t state;
    state_t state_next;

    // deferred request
    logic                        def_load;
    logic                        def_write;
    pkt_buffer_pkg::cpu_target_e def_target;
    logic [ADDR_W-1:0]           def_addr;
    pkt_buffer_pkg::pkt_entry_t  def_pkt;
    pkt_buffer_pkg::rank_entry_t def_rank;

    // cpu access issued on port a this cycle
    logic                        cpu_go;
    logic                        go_write;
    pkt_buffer_pkg::cpu_target_e go_target;
    logic [ADDR_W-1:0]           go_addr;
    pkt_buffer_pkg::pkt_entry_t  go_pkt;
    pkt_buffer_pkg::rank_entry_t go_rank;

    // response pipeline
    logic                        s1_valid;
    logic                        s1_write;
    pkt_buffer_pkg::cpu_target_e s1_target;
    logic                        s2_valid;
    logic                        s2_write;

    assign cpu_req_ready = (state == ST_IDLE);

    //////////////////////////////////////////////////////////////////////
    // deferral fsm
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        def_load   = 1'b0;
        cpu_go     = 1'b0;
        go_write   = cpu_req_write;
        go_target  = cpu_req_target;
        go_addr    = cpu_req_addr;
        go_pkt     = cpu_wr_pkt;
        go_rank    = cpu_wr_rank;

        case (state)
            ST_IDLE:
            begin
                if (cpu_req_valid)
                begin
                    if (dp_wr_en)
                    begin
                        def_load   = 1'b1;  // port a busy, park it
                        state_next = ST_WAIT_DP_IDLE;
                    end
                    else
                    begin
                        cpu_go = 1'b1;
                    end
                end
            end
            ST_WAIT_DP_IDLE:
            begin
                go_write  = def_write;
                go_target = def_target;
                go_addr   = def_addr;
                go_pkt    = def_pkt;
                go_rank   = def_rank;
                if (!dp_wr_en)
                begin
                    cpu_go     = 1'b1;
                    state_next = ST_IDLE;
                end
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // port a mux, datapath by default
    always_comb
    begin
        pkt_a.en     = dp_wr_en;
        pkt_a.we     = dp_wr_en;
        pkt_a.addr   = dp_wr_addr;
        pkt_a.wdata  = dp_wr_pkt;
        rank_a.en    = dp_wr_en;
        rank_a.we    = dp_wr_en;
        rank_a.addr  = dp_wr_addr;
        rank_a.wdata = dp_wr_rank;

        if (cpu_go)
        begin
            if (go_target == pkt_buffer_pkg::TARGET_PKT)
            begin
                pkt_a.en    = 1'b1;
                pkt_a.we    = go_write;
                pkt_a.addr  = go_addr;
                pkt_a.wdata = go_pkt;
            end
            else
            begin
                rank_a.en    = 1'b1;
                rank_a.we    = go_write;
                rank_a.addr  = go_addr;
                rank_a.wdata = go_rank;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (def_load)
        begin
            def_write  <= cpu_req_write;
            def_target <= cpu_req_target;
            def_addr   <= cpu_req_addr;
            def_pkt    <= cpu_wr_pkt;
            def_rank   <= cpu_wr_rank;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response pipeline and read data registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            s1_valid    <= 1'b0;
            s1_write    <= 1'b0;
            s1_target   <= pkt_buffer_pkg::TARGET_PKT;
            s2_valid    <= 1'b0;
            s2_write    <= 1'b0;
            cpu_rd_pkt  <= '0;
            cpu_rd_rank <= '0;
        end
        else
        begin
            s1_valid  <= cpu_go;
            s1_write  <= go_write;
            s1_target <= go_target;
            s2_valid  <= s1_valid;
            s2_write  <= s1_write;

            // rdata is valid in stage 1
            if (s1_valid && !s1_write)
            begin
                if (s1_target == pkt_buffer_pkg::TARGET_PKT)
                begin
                    cpu_rd_pkt <= pkt_a.rdata;
                end
                else
                begin
                    cpu_rd_rank <= rank_a.rdata;
                end
            end
        end
    end

    assign cpu_resp_valid = s2_valid;
    assign cpu_resp_write = s2_write;

endmodule

/* logic/ram_port_a_if.sv */
`timescale 1ns/10ps

// shared read/write port of one buffer
interface ram_port_a_if #(
    parameter type entry_t = logic,
    parameter int  ADDR_W  = pkt_buffer_pkg::ADDR_W_DEFAULT
);

    logic              en;
    logic              we;     // write when high, else read
    logic [ADDR_W-1:0] addr;
    entry_t            wdata;
    entry_t            rdata;  // one cycle after en, read-first

    modport arbiter (
        output en, we, addr, wdata,
        input  rdata
    );

    modport memory (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

/* sim.f */
logic/pkt_buffer_pkg.sv
logic/ram_port_a_if.sv
logic/buffer_ram.sv
logic/port_a_arbiter.sv
logic/pkt_buffer_top.sv
tb/tb_pkt_buffer.sv

/* tb/tb_pkt_buffer.sv */
`timescale 1ns/10ps

module tb_pkt_buffer;

    localparam int ADDR_W     = pkt_buffer_pkg::ADDR_W_DEFAULT;
    localparam int MAX_CYCLES = 4000;

    // expected response with the cycle it is due in
    typedef struct packed {
        int                          due;
        logic                        write;
        logic                        target;
        pkt_buffer_pkg::pkt_entry_t  pkt;
        pkt_buffer_pkg::rank_entry_t rank;
    } exp_t;

    typedef struct packed {
        logic                        write;
        logic                        target;
        logic [ADDR_W-1:0]           addr;
        pkt_buffer_pkg::pkt_entry_t  pkt;
        pkt_buffer_pkg::rank_entry_t rank;
    } req_t;

    logic                        clk;
    logic                        rstn;
    logic                        dp_wr_en;
    logic [ADDR_W-1:0]           dp_wr_addr;
    pkt_buffer_pkg::pkt_entry_t  dp_wr_pkt;
    pkt_buffer_pkg::rank_entry_t dp_wr_rank;
    logic                        dp_rd_en;
    logic [ADDR_W-1:0]           dp_rd_addr;
    logic                        m_valid;
    pkt_buffer_pkg::pkt_entry_t  m_pkt;
    pkt_buffer_pkg::rank_entry_t m_rank;
    logic                        cpu_req_valid;
    logic                        cpu_req_write;
    pkt_buffer_pkg::cpu_target_e cpu_req_target;
    logic [ADDR_W-1:0]           cpu_req_addr;
    pkt_buffer_pkg::pkt_entry_t  cpu_wr_pkt;
    pkt_buffer_pkg::rank_entry_t cpu_wr_rank;
    logic                        cpu_req_ready;
    logic                        cpu_resp_valid;
    logic                        cpu_resp_write;
    pkt_buffer_pkg::pkt_entry_t  cpu_rd_pkt;
    pkt_buffer_pkg::rank_entry_t cpu_rd_rank;

    // shadow memories and model state
    pkt_buffer_pkg::pkt_entry_t  pkt_mem [int];
    pkt_buffer_pkg::rank_entry_t rank_mem [int];
    exp_t m_q [$];
    exp_t resp_q [$];
    req_t held;
    logic deferred  = 1'b0;
    int   cyc       = 0;
    int   defer_cnt = 0;
    int   data_errs = 0;
    int   prot_errs = 0;

    pkt_buffer_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic exp_t ref_read(input logic target, input int addr);
        exp_t e;
        e = '0;
        if (target == pkt_buffer_pkg::TARGET_PKT)
        begin
            e.pkt = pkt_mem.exists(addr) ? pkt_mem[addr] : 'x;
        end
        else
        begin
            e.rank = rank_mem.exists(addr) ? rank_mem[addr] : 'x;
        end
        return e;
    endfunction

    function automatic pkt_buffer_pkg::pkt_entry_t rand_pkt();
        pkt_buffer_pkg::pkt_entry_t p;
        p.last = $urandom_range(0, 1);
        p.keep = $urandom_range(0, 255);
        p.data = {$urandom, $urandom};
        return p;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model on every rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        exp_t e;
        exp_t r;
        req_t cur;
        logic go;
        cyc = cyc + 1;
        go  = 1'b0;
        cur = {cpu_req_write, cpu_req_target, cpu_req_addr, cpu_wr_pkt, cpu_wr_rank};
        if (!rstn)
        begin
            deferred = 1'b0;
        end
        else
        begin
            if (dp_rd_en)
            begin
                e      = ref_read(pkt_buffer_pkg::TARGET_PKT, dp_rd_addr);
                r      = ref_read(pkt_buffer_pkg::TARGET_RANK, dp_rd_addr);
                e.rank = r.rank;
                e.due  = cyc;  // old value on same-cycle write
                m_q.push_back(e);
            end
            if (deferred && !dp_wr_en)
            begin
                go       = 1'b1;
                deferred = 1'b0;
                cur      = held;
            end
            else if (!deferred && cpu_req_valid)
            begin
                if (dp_wr_en)
                begin
                    held     = cur;
                    deferred = 1'b1;
                    defer_cnt++;
                end
                else
                begin
                    go = 1'b1;
                end
            end
            if (go)
            begin
                e        = ref_read(cur.target, cur.addr);
                e.due    = cyc + 1;  // two cycles after the access
                e.write  = cur.write;
                e.target = cur.target;
                resp_q.push_back(e);
                if (cur.write && cur.target == pkt_buffer_pkg::TARGET_PKT)
                begin
                    pkt_mem[cur.addr] = cur.pkt;
                end
                else if (cur.write)
                begin
                    rank_mem[cur.addr] = cur.rank;
                end
            end
            if (dp_wr_en)
            begin
                pkt_mem[dp_wr_addr]  = dp_wr_pkt;
                rank_mem[dp_wr_addr] = dp_wr_rank;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // comparison at the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        exp_t e;
        if (cyc >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
        else if (rstn)
        begin
            assert (cpu_req_ready === !deferred)
            else
            begin
                prot_errs++;
                $display("Error at %0t: cpu_req_ready is %b", $time, cpu_req_ready);
            end
            if (m_valid !== 1'b0 || (m_q.size() > 0 && m_q[0].due <= cyc))
            begin
                e = (m_q.size() > 0) ? m_q.pop_front() : '0;
                assert (m_valid === 1'b1 && e.due == cyc)
                else
                begin
                    prot_errs++;
                    $display("Error at %0t: m_valid %b, expected at cycle %0d", $time,
                             m_valid, e.due);
                end
                assert (m_pkt === e.pkt && m_rank === e.rank)
                else
                begin
                    data_errs++;
                    $display("Error at %0t: port b read %h/%h, expected %h/%h", $time,
                             m_pkt, m_rank, e.pkt, e.rank);
                end
            end
            if (cpu_resp_valid !== 1'b0 || (resp_q.size() > 0 && resp_q[0].due <= cyc))
            begin
                e = (resp_q.size() > 0) ? resp_q.pop_front() : '0;
                assert (cpu_resp_valid === 1'b1 && e.due == cyc && cpu_resp_write === e.write)
                else
                begin
                    prot_errs++;
                    $display("Error at %0t: cpu response valid %b write %b, expected cycle %0d",
                             $time, cpu_resp_valid, cpu_resp_write, e.due);
                end
                assert (e.write || (e.target ? cpu_rd_rank === e.rank : cpu_rd_pkt === e.pkt))
                else
                begin
                    data_errs++;
                    $display("Error at %0t: cpu read %h/%h, expected %h/%h", $time,
                             cpu_rd_pkt, cpu_rd_rank, e.pkt, e.rank);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic dp_write(input logic [ADDR_W-1:0] addr);
        dp_wr_en   = 1'b1;
        dp_wr_addr = addr;
        dp_wr_pkt  = rand_pkt();
        dp_wr_rank = $urandom;
        @(negedge clk);
        dp_wr_en = 1'b0;
    endtask

    task automatic dp_read(input logic [ADDR_W-1:0] addr);
        dp_rd_en   = 1'b1;
        dp_rd_addr = addr;
        @(negedge clk);
        dp_rd_en = 1'b0;
    endtask

    // random writes and reads with a busy write side
    task automatic dp_burst(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            dp_wr_en   = ($urandom_range(0, 3) != 0);
            dp_wr_addr = $urandom;
            dp_wr_pkt  = rand_pkt();
            dp_wr_rank = $urandom;
            dp_rd_en   = ($urandom_range(0, 3) == 0);
            dp_rd_addr = $urandom;
            @(negedge clk);
        end
        dp_wr_en = 1'b0;
        dp_rd_en = 1'b0;
    endtask

    // holds the request until it is accepted
    task automatic cpu_request(input logic write, input logic target,
                               input logic [ADDR_W-1:0] addr);
        cpu_req_valid  = 1'b1;
        cpu_req_write  = write;
        cpu_req_target = pkt_buffer_pkg::cpu_target_e'(target);
        cpu_req_addr   = addr;
        cpu_wr_pkt     = rand_pkt();
        cpu_wr_rank    = $urandom;
        while (!cpu_req_ready)
        begin
            @(negedge clk);
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;
    endtask

    task automatic cpu_random(input int count);
        for (int i = 0; i < count; i++)
        begin
            cpu_request($urandom_range(0, 1), $urandom_range(0, 1), $urandom);
        end
    endtask

    initial
    begin
        int seed_dummy;
        seed_dummy     = $urandom(32'h1821_15dc);
        rstn           = 1'b0;
        dp_wr_en       = 1'b0;
        dp_wr_addr     = '0;
        dp_wr_pkt      = '0;
        dp_wr_rank     = '0;
        dp_rd_en       = 1'b0;
        dp_rd_addr     = '0;
        cpu_req_valid  = 1'b0;
        cpu_req_write  = 1'b0;
        cpu_req_target = pkt_buffer_pkg::TARGET_PKT;
        cpu_req_addr   = '0;
        cpu_wr_pkt     = '0;
        cpu_wr_rank    = '0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        repeat (20) @(negedge clk);  // idle after reset
        for (int i = 0; i < (1 << ADDR_W); i++)
        begin
            dp_write(i);
        end
        dp_burst(150);
        cpu_random(40);  // back to back with the datapath idle

        cpu_request(1'b1, pkt_buffer_pkg::TARGET_PKT, 8'h5a);
        cpu_request(1'b1, pkt_buffer_pkg::TARGET_RANK, 8'h5a);
        dp_read(8'h5a);
        dp_write(8'h3c);
        cpu_request(1'b0, pkt_buffer_pkg::TARGET_PKT, 8'h3c);
        cpu_request(1'b0, pkt_buffer_pkg::TARGET_RANK, 8'h3c);

        fork
            dp_burst(300);
            cpu_random(40);
        join
        for (int i = 0; i < (1 << ADDR_W); i++)
        begin
            dp_read(i);  // nothing lost
        end
        repeat (4) @(posedge clk);

        assert (defer_cnt > 0)
        else
        begin
            prot_errs++;
            $display("No CPU request was deferred during the datapath bursts");
        end
        $display("data errors %0d, protocol errors %0d", data_errs, prot_errs);
        if (data_errs + prot_errs == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
